/* verilog.f */
common/cache_cfg_pkg.sv
common/cache_bus_pkg.sv
cache/cache_front_end.sv
cache/cache_memory.sv
cache/cache_control.sv
cache/write_buffer.sv
cache/cache_back_end.sv
hw/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* bench/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb
   import cache_cfg_pkg::*, cache_bus_pkg::*;
();

   localparam int unsigned SEED = 32'hef95_8684;
   localparam int POLL_LIMIT    = 50;
   localparam int MIX_OPS       = 200;
   localparam int NUM_CACHED    = 5;
   // request count of each test in order, the drain test adds its polls
   localparam int NUM_REQS      = 25 + 43 + 16 + POLL_LIMIT + 14 + MIX_OPS;
   localparam int MAX_CYCLES    = NUM_REQS * 40 + 1000;

   typedef struct packed {
      logic            check;
      logic [ADDR_W:0] addr;
      word_t           data;
   } expect_t;

   logic              clk;
   logic              reset;
   logic [ADDR_W:0]   addr;
   word_t             wdata;
   wstrb_t            wstrb;
   logic              req;
   logic              ack;
   word_t             rdata;
   logic              mem_req;
   mem_req_t          mem;
   logic              mem_ack;
   word_t             mem_rdata;

   expect_t           expect_q [$];
   word_t             shadow_mem [1 << WADDR_W];
   logic [NLINES-1:0] shadow_valid;
   tag_t              shadow_tag [NLINES];
   int                exp_hits;
   int                exp_misses;
   int                errors;
   int                test_start_errors;
   int                tests_run;
   int                tests_failed;
   string             test_name;
   addr_t             cached_addrs [NUM_CACHED];

   cache_top dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .req       (req),
      .ack       (ack),
      .rdata     (rdata),
      .mem_req   (mem_req),
      .mem       (mem),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   mem_model ext_mem (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem       (mem),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, a request was never acknowledged", MAX_CYCLES);
      $display("Regression failed");
      $finish;
   end

   function automatic word_t apply_strobes(word_t old_word, word_t new_word, wstrb_t strobe);
      word_t merged;
      merged = old_word;
      for (int b = 0; b < NBYTES; b++) begin
         if (strobe[b]) begin
            merged[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return merged;
   endfunction

   function automatic waddr_t word_index(addr_t a);
      return a[ADDR_W-1:BYTE_OFF_W];
   endfunction

   function automatic index_t line_index(addr_t a);
      return a[BYTE_OFF_W+OFFSET_W +: INDEX_W];
   endfunction

   function automatic tag_t line_tag(addr_t a);
      return a[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic logic predict_hit(addr_t a);
      return shadow_valid[line_index(a)] && (shadow_tag[line_index(a)] == line_tag(a));
   endfunction

   // only read misses allocate a line
   function automatic void note_lookup(addr_t a, logic is_write);
      if (predict_hit(a)) begin
         exp_hits++;
      end else begin
         exp_misses++;
         if (!is_write) begin
            shadow_valid[line_index(a)] = 1'b1;
            shadow_tag[line_index(a)]   = line_tag(a);
         end
      end
   endfunction

   function automatic addr_t random_addr(tag_t tag_base, int unsigned lines);
      tag_t    t;
      index_t  idx;
      offset_t off;
      t   = tag_base + tag_t'($urandom_range(1, 0));
      idx = index_t'($urandom_range(lines - 1, 0));
      off = offset_t'($urandom_range(LINE_WORDS - 1, 0));
      return {t, idx, off, {BYTE_OFF_W{1'b0}}};
   endfunction

   function automatic wstrb_t random_strobe();
      return wstrb_t'($urandom_range(15, 1));
   endfunction

   // one host request held until ack
   task automatic host_access(input logic [ADDR_W:0] a, input word_t d, input wstrb_t s,
                              input logic check, input word_t exp_data,
                              output word_t result);
      expect_t e;
      @(negedge clk);
      e.check = check;
      e.addr  = a;
      e.data  = exp_data;
      expect_q.push_back(e);
      addr  = a;
      wdata = d;
      wstrb = s;
      req   = 1'b1;
      do begin
         @(posedge clk);
      end while (!ack);
      result = rdata;
      @(negedge clk);
      req   = 1'b0;
      wstrb = '0;
   endtask

   task automatic write_word(input addr_t a, input word_t d, input wstrb_t s);
      word_t unused;
      note_lookup(a, 1'b1);
      shadow_mem[word_index(a)] = apply_strobes(shadow_mem[word_index(a)], d, s);
      host_access({1'b0, a}, d, s, 1'b0, '0, unused);
   endtask

   task automatic read_word(input addr_t a);
      word_t unused;
      note_lookup(a, 1'b0);
      host_access({1'b0, a}, '0, '0, 1'b1, shadow_mem[word_index(a)], unused);
   endtask

   task automatic write_register(input ctrl_addr_t r);
      word_t unused;
      host_access({1'b1, {(ADDR_W-CTRL_ADDR_W){1'b0}}, r}, 32'h1, '1, 1'b0, '0, unused);
      if (r == CTRL_INVALIDATE) begin
         shadow_valid = '0;
      end
      if (r == CTRL_CLEAR) begin
         exp_hits   = 0;
         exp_misses = 0;
      end
   endtask

   task automatic check_register(input ctrl_addr_t r, input word_t exp_data);
      word_t unused;
      host_access({1'b1, {(ADDR_W-CTRL_ADDR_W){1'b0}}, r}, '0, '0, 1'b1, exp_data, unused);
   endtask

   task automatic read_register(input ctrl_addr_t r, output word_t value);
      host_access({1'b1, {(ADDR_W-CTRL_ADDR_W){1'b0}}, r}, '0, '0, 1'b0, '0, value);
   endtask

   task automatic wait_mem_idle();
      do begin
         @(posedge clk);
      end while (mem_req);
   endtask

   task automatic start_test(input string name);
      test_name         = name;
      test_start_errors = errors;
      tests_run++;
   endtask

   task automatic finish_test();
      if (errors == test_start_errors) begin
         $display("test %s: pass", test_name);
      end else begin
         $display("test %s: FAIL with %0d errors", test_name, errors - test_start_errors);
         tests_failed++;
      end
   endtask

   // every ack answers the oldest outstanding request
   always @(posedge clk) begin : compare
      expect_t e;
      if (!reset && ack) begin
         if (expect_q.size() == 0) begin
            $display("unexpected ack in test %s with no request outstanding", test_name);
            errors++;
         end else begin
            e = expect_q.pop_front();
            if (e.check) begin
               assert (rdata == e.data)
               else begin
                  $display("ERROR %s: addr %h expected %h actual %h",
                           test_name, e.addr, e.data, rdata);
                  errors++;
               end
            end
         end
      end
   end

   initial begin : main
      int unsigned seed_word;
      word_t       value;
      addr_t       a;
      addr_t       touched [$];
      addr_t       line_seen [$];
      int          polls;
      logic        is_new;

      seed_word = $urandom(SEED);
      reset     = 1'b1;
      req       = 1'b0;
      addr      = '0;
      wdata     = '0;
      wstrb     = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      exp_hits     = 0;
      exp_misses   = 0;
      shadow_valid = '0;
      test_name    = "reset";
      cached_addrs[0] = 16'h0000;
      cached_addrs[1] = 16'h0004;
      cached_addrs[2] = 16'h0100;
      cached_addrs[3] = 16'h0048;
      cached_addrs[4] = 16'h1048;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // shadow starts from the memory model's own contents
      for (int i = 0; i < (1 << WADDR_W); i++) begin
         shadow_mem[i] = ext_mem.words[i];
      end

      // same index with a second tag forces evictions
      start_test("write_then_read");
      foreach (cached_addrs[i]) begin
         write_word(cached_addrs[i], $urandom, '1);
         read_word(cached_addrs[i]);
         write_word(cached_addrs[i], $urandom, random_strobe());
         read_word(cached_addrs[i]);
         read_word(cached_addrs[i]);
      end
      finish_test();

      start_test("hit_miss_count");
      write_register(CTRL_CLEAR);
      repeat (40) begin
         a = random_addr(8'h20, 4);
         if ($urandom_range(1, 0) == 1) begin
            write_word(a, $urandom, random_strobe());
         end else begin
            read_word(a);
         end
      end
      check_register(CTRL_HITS, word_t'(exp_hits));
      check_register(CTRL_MISSES, word_t'(exp_misses));
      finish_test();

      start_test("wbuf_drain");
      repeat (16) begin
         a = random_addr(8'h50, 16);
         write_word(a, $urandom, random_strobe());
         touched.push_back(a);
      end
      value = '0;
      polls = 0;
      while (value[0] !== 1'b1 && polls < POLL_LIMIT) begin
         read_register(CTRL_WBUF_EMPTY, value);
         polls++;
      end
      assert (value[0] === 1'b1)
      else begin
         $display("write buffer still not empty after %0d polls in test %s", polls, test_name);
         errors++;
      end
      // the last popped write can still be on the memory bus
      wait_mem_idle();
      foreach (touched[i]) begin
         assert (ext_mem.words[word_index(touched[i])] == shadow_mem[word_index(touched[i])])
         else begin
            $display("ERROR %s: memory word %h expected %h actual %h", test_name,
                     word_index(touched[i]), shadow_mem[word_index(touched[i])],
                     ext_mem.words[word_index(touched[i])]);
            errors++;
         end
      end
      finish_test();

      start_test("invalidate_clear");
      // bring the addresses into the cache first
      foreach (cached_addrs[i]) begin
         read_word(cached_addrs[i]);
      end
      write_register(CTRL_INVALIDATE);
      write_register(CTRL_CLEAR);
      // reverse order so a line left valid would hit
      for (int i = NUM_CACHED - 1; i >= 0; i--) begin
         read_word(cached_addrs[i]);
         // count each line once
         is_new = 1'b1;
         foreach (line_seen[j]) begin
            if (line_seen[j] == (cached_addrs[i] >> (BYTE_OFF_W + OFFSET_W))) begin
               is_new = 1'b0;
            end
         end
         if (is_new) begin
            line_seen.push_back(cached_addrs[i] >> (BYTE_OFF_W + OFFSET_W));
         end
      end
      check_register(CTRL_MISSES, word_t'(line_seen.size()));
      check_register(CTRL_HITS, word_t'(exp_hits));
      finish_test();

      // mostly writes so the buffer runs full behind slow memory
      start_test("random_mix");
      repeat (MIX_OPS) begin
         a = random_addr(8'h60, 8);
         if ($urandom_range(9, 0) < 7) begin
            write_word(a, $urandom, random_strobe());
         end else begin
            read_word(a);
         end
      end
      finish_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ns

module mem_model
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     mem_req,
   input  mem_req_t mem,
   output logic     mem_ack,
   output word_t    mem_rdata
);

   word_t words [1 << WADDR_W];

   // pattern built from every word address bit
   function automatic word_t fill_word(waddr_t a);
      return {2'b10, a, 2'b01, ~a};
   endfunction

   // one access at a time, acked 0 to 3 cycles after it is seen
   initial begin : serve
      int delay;
      for (int i = 0; i < (1 << WADDR_W); i++) begin
         words[i] = fill_word(waddr_t'(i));
      end
      mem_ack   = 1'b0;
      mem_rdata = '0;
      forever begin
         @(negedge clk);
         mem_ack = 1'b0;
         if (mem_req && !reset) begin
            delay = $urandom_range(3, 0);
            repeat (delay) @(negedge clk);
            if (mem.write) begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (mem.wstrb[b]) begin
                     words[mem.addr][8*b +: 8] = mem.data[8*b +: 8];
                  end
               end
            end else begin
               mem_rdata = words[mem.addr];
            end
            mem_ack = 1'b1;
         end
      end
   end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ns

module cache_top
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [ADDR_W:0] addr,
   input  word_t       wdata,
   input  wstrb_t      wstrb,
   input  logic        req,
   output logic        ack,
   output word_t       rdata,
   output logic        mem_req,
   output mem_req_t    mem,
   input  logic        mem_ack,
   input  word_t       mem_rdata
);

   logic        data_req;
   logic        data_req_reg;
   front_req_t  front_req;
   logic        data_ack;
   word_t       data_rdata;
   logic        ctrl_req;
   ctrl_addr_t  ctrl_addr;
   logic        ctrl_ack;
   word_t       ctrl_rdata;
   logic        wbuf_push;
   wbuf_entry_t wbuf_entry;
   logic        wbuf_pop;
   wbuf_entry_t wbuf_head;
   logic        wbuf_full;
   logic        wbuf_empty;
   logic        fill_start;
   waddr_t      fill_addr;
   logic        fill_valid;
   logic        fill_done;
   word_t       fill_data;
   logic        hit;
   logic        miss;
   logic        invalidate;

   cache_front_end front_end (
      .clk          (clk),
      .reset        (reset),
      .addr         (addr),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .req          (req),
      .ack          (ack),
      .rdata        (rdata),
      .data_req     (data_req),
      .data_req_reg (data_req_reg),
      .front_req    (front_req),
      .data_ack     (data_ack),
      .data_rdata   (data_rdata),
      .ctrl_req     (ctrl_req),
      .ctrl_addr    (ctrl_addr),
      .ctrl_ack     (ctrl_ack),
      .ctrl_rdata   (ctrl_rdata)
   );

   cache_memory memory (
      .clk          (clk),
      .reset        (reset),
      .data_req     (data_req),
      .data_req_reg (data_req_reg),
      .front_req    (front_req),
      .data_ack     (data_ack),
      .data_rdata   (data_rdata),
      .wbuf_push    (wbuf_push),
      .wbuf_entry   (wbuf_entry),
      .wbuf_full    (wbuf_full),
      .wbuf_empty   (wbuf_empty),
      .fill_start   (fill_start),
      .fill_addr    (fill_addr),
      .fill_valid   (fill_valid),
      .fill_done    (fill_done),
      .fill_data    (fill_data),
      .hit          (hit),
      .miss         (miss),
      .invalidate   (invalidate)
   );

   // control writes use the registered host data
   cache_control control (
      .clk        (clk),
      .reset      (reset),
      .ctrl_req   (ctrl_req),
      .ctrl_addr  (ctrl_addr),
      .ctrl_wdata (front_req.wdata),
      .ctrl_write (front_req.write),
      .ctrl_ack   (ctrl_ack),
      .ctrl_rdata (ctrl_rdata),
      .hit        (hit),
      .miss       (miss),
      .wbuf_empty (wbuf_empty),
      .invalidate (invalidate)
   );

   write_buffer wbuf (
      .clk        (clk),
      .reset      (reset),
      .push       (wbuf_push),
      .push_entry (wbuf_entry),
      .pop        (wbuf_pop),
      .head       (wbuf_head),
      .full       (wbuf_full),
      .empty      (wbuf_empty)
   );

   cache_back_end back_end (
      .clk        (clk),
      .reset      (reset),
      .wbuf_head  (wbuf_head),
      .wbuf_empty (wbuf_empty),
      .wbuf_pop   (wbuf_pop),
      .fill_start (fill_start),
      .fill_addr  (fill_addr),
      .fill_valid (fill_valid),
      .fill_done  (fill_done),
      .fill_data  (fill_data),
      .mem_req    (mem_req),
      .mem        (mem),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata)
   );

endmodule

/* cache/cache_back_end.sv */
`timescale 1ns/1ns

module cache_back_end
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  wbuf_entry_t wbuf_head,
   input  logic        wbuf_empty,
   output logic        wbuf_pop,
   input  logic        fill_start,
   input  waddr_t      fill_addr,
   output logic        fill_valid,
   output logic        fill_done,
   output word_t       fill_data,
   output logic        mem_req,
   output mem_req_t    mem,
   input  logic        mem_ack,
   input  word_t       mem_rdata
);

   back_state_e state;
   logic        fill_pending;
   waddr_t      fill_base;
   offset_t     word_cnt;
   logic        start_write;

   // pending writes always go first
   assign start_write = (state == BS_IDLE) && !wbuf_empty;
   assign wbuf_pop    = start_write;

   assign fill_valid = (state == BS_FILL_WAIT) && mem_ack;
   assign fill_done  = fill_valid && (word_cnt == offset_t'(LINE_WORDS-1));
   assign fill_data  = mem_rdata;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state        <= BS_IDLE;
         mem_req      <= 1'b0;
         fill_pending <= 1'b0;
         word_cnt     <= '0;
      end else begin
         if (fill_start) begin
            fill_pending <= 1'b1;
         end
         case (state)
            BS_IDLE: begin
               if (start_write) begin
                  mem_req <= 1'b1;
                  state   <= BS_WRITE;
               end else if (fill_pending) begin
                  state <= BS_FILL_REQ;
               end
            end
            BS_WRITE: begin
               if (mem_ack) begin
                  mem_req <= 1'b0;
                  state   <= BS_IDLE;
               end
            end
            BS_FILL_REQ: begin
               mem_req <= 1'b1;
               state   <= BS_FILL_WAIT;
            end
            default: begin
               if (mem_ack) begin
                  mem_req  <= 1'b0;
                  word_cnt <= word_cnt + 1'b1;
                  if (fill_done) begin
                     fill_pending <= 1'b0;
                     state        <= BS_IDLE;
                  end else begin
                     state <= BS_FILL_REQ;
                  end
               end
            end
         endcase
      end
   end

   // request fields, loaded only when a new access starts
   always_ff @(posedge clk) begin
      if (fill_start) begin
         fill_base <= fill_addr;
      end
      if (start_write) begin
         mem <= '{addr: wbuf_head.waddr, data: wbuf_head.data,
                  wstrb: wbuf_head.wstrb, write: 1'b1};
      end else if (state == BS_FILL_REQ) begin
         mem <= '{addr: {fill_base[WADDR_W-1:OFFSET_W], word_cnt}, data: '0,
                  wstrb: '0, write: 1'b0};
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      mem_req && !mem_ack |=> mem_req && $stable(mem));

endmodule

/* cache/write_buffer.sv */
`timescale 1ns/1ns

module write_buffer
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        push,
   input  wbuf_entry_t push_entry,
   input  logic        pop,
   output wbuf_entry_t head,
   output logic        full,
   output logic        empty
);

   wbuf_entry_t           entries [WBUF_DEPTH];
   logic [WBUF_PTR_W-1:0] wr_ptr;
   logic [WBUF_PTR_W-1:0] rd_ptr;
   logic [WBUF_PTR_W:0]   count;

   assign full  = (count == (WBUF_PTR_W+1)'(WBUF_DEPTH));
   assign empty = (count == '0);
   assign head  = entries[rd_ptr];

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_entry;
      end
   end

   assert property (@(posedge clk) disable iff (reset) push |-> !full);
   assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

/* cache/cache_control.sv */
`timescale 1ns/1ns

module cache_control
   import cache_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ctrl_req,
   input  ctrl_addr_t ctrl_addr,
   input  word_t      ctrl_wdata,
   input  logic       ctrl_write,
   output logic       ctrl_ack,
   output word_t      ctrl_rdata,
   input  logic       hit,
   input  logic       miss,
   input  logic       wbuf_empty,
   output logic       invalidate
);

   count_t hits_cnt;
   count_t misses_cnt;
   logic   reg_write;

   // writes take effect in the ack cycle, wdata is registered by then
   assign reg_write  = ctrl_ack && ctrl_write;
   assign invalidate = reg_write && (ctrl_addr == CTRL_INVALIDATE);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ack   <= 1'b0;
         hits_cnt   <= '0;
         misses_cnt <= '0;
      end else begin
         ctrl_ack <= ctrl_req && !ctrl_ack;
         if (reg_write && (ctrl_addr == CTRL_CLEAR)) begin
            hits_cnt   <= '0;
            misses_cnt <= '0;
         end else begin
            // counters can also be preset by a direct write
            if (reg_write && (ctrl_addr == CTRL_HITS)) begin
               hits_cnt <= ctrl_wdata;
            end else if (hit) begin
               hits_cnt <= hits_cnt + 1'b1;
            end
            if (reg_write && (ctrl_addr == CTRL_MISSES)) begin
               misses_cnt <= ctrl_wdata;
            end else if (miss) begin
               misses_cnt <= misses_cnt + 1'b1;
            end
         end
      end
   end

   always_comb begin
      case (ctrl_addr)
         CTRL_HITS:       ctrl_rdata = hits_cnt;
         CTRL_MISSES:     ctrl_rdata = misses_cnt;
         CTRL_WBUF_EMPTY: ctrl_rdata = word_t'(wbuf_empty);
         default:         ctrl_rdata = '0;
      endcase
   end

endmodule

/* cache/cache_memory.sv */
`timescale 1ns/1ns

module cache_memory
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        data_req,
   input  logic        data_req_reg,
   input  front_req_t  front_req,
   output logic        data_ack,
   output word_t       data_rdata,
   output logic        wbuf_push,
   output wbuf_entry_t wbuf_entry,
   input  logic        wbuf_full,
   input  logic        wbuf_empty,
   output logic        fill_start,
   output waddr_t      fill_addr,
   input  logic        fill_valid,
   input  logic        fill_done,
   input  word_t       fill_data,
   output logic        hit,
   output logic        miss,
   input  logic        invalidate
);

   cache_state_e      state;
   logic [NLINES-1:0] valid;
   tag_t              tag_mem [NLINES];
   word_t             data_mem [NLINES*LINE_WORDS];
   offset_t           fill_cnt;

   tag_t    req_tag;
   index_t  req_index;
   offset_t req_offset;
   logic    lookup_hit;
   logic    idle_req;
   logic    accept_write;
   logic    read_hit;
   logic    read_miss;

   // split the registered byte address
   assign req_tag    = front_req.addr[ADDR_W-1 -: TAG_W];
   assign req_index  = front_req.addr[BYTE_OFF_W+OFFSET_W +: INDEX_W];
   assign req_offset = front_req.addr[BYTE_OFF_W +: OFFSET_W];

   assign lookup_hit = valid[req_index] && (tag_mem[req_index] == req_tag);

   assign idle_req     = (state == CS_IDLE) && data_req_reg;
   // a write waits in idle until the buffer has a free slot
   assign accept_write = idle_req && front_req.write && !wbuf_full;
   assign read_hit     = idle_req && !front_req.write && lookup_hit;
   assign read_miss    = idle_req && !front_req.write && !lookup_hit;

   assign hit  = read_hit || (accept_write && lookup_hit);
   assign miss = read_miss || (accept_write && !lookup_hit);

   assign data_ack   = accept_write || read_hit || (state == CS_RESPOND);
   assign data_rdata = data_mem[{req_index, req_offset}];

   // every write goes through, hit or miss
   assign wbuf_push  = accept_write;
   assign wbuf_entry = '{
      waddr: front_req.addr[ADDR_W-1:BYTE_OFF_W],
      data:  front_req.wdata,
      wstrb: front_req.wstrb
   };

   // fill only once older writes have left the buffer
   assign fill_start = (state == CS_WAIT_DRAIN) && wbuf_empty;
   assign fill_addr  = {req_tag, req_index, {OFFSET_W{1'b0}}};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= CS_IDLE;
         valid    <= '0;
         fill_cnt <= '0;
      end else begin
         case (state)
            CS_IDLE:
               if (read_miss) state <= CS_WAIT_DRAIN;
            CS_WAIT_DRAIN:
               if (wbuf_empty) state <= CS_FILL;
            CS_FILL:
               if (fill_done) state <= CS_RESPOND;
            default:
               state <= CS_IDLE;
         endcase

         // wraps back to zero after the last word
         if (fill_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
         end

         if (invalidate) begin
            valid <= '0;
         end else if (fill_done) begin
            valid[req_index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_valid) begin
         data_mem[{req_index, fill_cnt}] <= fill_data;
      end
      if (fill_done) begin
         tag_mem[req_index] <= req_tag;
      end
      // merge strobed bytes on a write hit
      if (accept_write && lookup_hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (front_req.wstrb[b]) begin
               data_mem[{req_index, req_offset}][8*b +: 8] <= front_req.wdata[8*b +: 8];
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) fill_valid |-> state == CS_FILL);

   // host holds a missing read until it is answered
   assert property (@(posedge clk) disable iff (reset) (state != CS_IDLE) |-> data_req);

endmodule

/* cache/cache_front_end.sv */
`timescale 1ns/1ns

module cache_front_end
   import cache_cfg_pkg::*, cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [ADDR_W:0] addr,
   input  word_t       wdata,
   input  wstrb_t      wstrb,
   input  logic        req,
   output logic        ack,
   output word_t       rdata,
   output logic        data_req,
   output logic        data_req_reg,
   output front_req_t  front_req,
   input  logic        data_ack,
   input  word_t       data_rdata,
   output logic        ctrl_req,
   output ctrl_addr_t  ctrl_addr,
   input  logic        ctrl_ack,
   input  word_t       ctrl_rdata
);

   logic sel_ctrl;
   logic data_req_int;

   // top address bit picks the control register space
   assign sel_ctrl     = addr[ADDR_W];
   assign data_req_int = req && !sel_ctrl;
   assign ctrl_req     = req && sel_ctrl;
   assign ctrl_addr    = addr[CTRL_ADDR_W-1:0];

   assign data_req = data_req_int || data_req_reg;

   // only one side answers a given request
   assign ack   = data_ack || ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

   // drop the registered copy once acked so it is not seen twice
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         data_req_reg <= 1'b0;
      end else begin
         data_req_reg <= data_req_int && !data_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         front_req <= '{addr: addr[ADDR_W-1:0], wdata: wdata, wstrb: wstrb, write: |wstrb};
      end
   end

   assert property (@(posedge clk) disable iff (reset) !(data_ack && ctrl_ack));

endmodule

/* common/cache_bus_pkg.sv */
package cache_bus_pkg;
   import cache_cfg_pkg::*;

   // host request as held by the front end
   typedef struct packed {
      addr_t  addr;
      word_t  wdata;
      wstrb_t wstrb;
      logic   write;
   } front_req_t;

   // one pending write-through
   typedef struct packed {
      waddr_t waddr;
      word_t  data;
      wstrb_t wstrb;
   } wbuf_entry_t;

   // external memory access, word addressed
   typedef struct packed {
      waddr_t addr;
      word_t  data;
      wstrb_t wstrb;
      logic   write;
   } mem_req_t;

   typedef enum logic [1:0] {
      CS_IDLE,
      CS_WAIT_DRAIN,
      CS_FILL,
      CS_RESPOND
   } cache_state_e;

   typedef enum logic [1:0] {
      BS_IDLE,
      BS_WRITE,
      BS_FILL_REQ,
      BS_FILL_WAIT
   } back_state_e;

endpackage

/* common/cache_cfg_pkg.sv */
package cache_cfg_pkg;

   // host side sizes
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int NBYTES      = DATA_W / 8;
   localparam int CTRL_ADDR_W = 3;

   // cache geometry
   localparam int NLINES     = 16;
   localparam int LINE_WORDS = 4;
   localparam int WBUF_DEPTH = 4;

   // address fields, byte offset at the bottom and tag at the top
   localparam int BYTE_OFF_W = $clog2(NBYTES);
   localparam int OFFSET_W   = $clog2(LINE_WORDS);
   localparam int INDEX_W    = $clog2(NLINES);
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
   localparam int WADDR_W    = ADDR_W - BYTE_OFF_W;
   localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

   typedef logic [ADDR_W-1:0]      addr_t;
   typedef logic [WADDR_W-1:0]     waddr_t;
   typedef logic [DATA_W-1:0]      word_t;
   typedef logic [NBYTES-1:0]      wstrb_t;
   typedef logic [TAG_W-1:0]       tag_t;
   typedef logic [INDEX_W-1:0]     index_t;
   typedef logic [OFFSET_W-1:0]    offset_t;
   typedef logic [31:0]            count_t;
   typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;

   // control register map
   localparam ctrl_addr_t CTRL_HITS       = 3'd0;
   localparam ctrl_addr_t CTRL_MISSES     = 3'd1;
   localparam ctrl_addr_t CTRL_WBUF_EMPTY = 3'd2;
   localparam ctrl_addr_t CTRL_INVALIDATE = 3'd3;
   localparam ctrl_addr_t CTRL_CLEAR      = 3'd4;

endpackage
